// File: verilog.f
common/up_pkg.sv
up_core/up_datapath.sv
up_core/up_control.sv
hdl/up_memory.sv
hdl/up_top.sv
sim/up_tb_checks.sv
sim/up_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= up_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "FAIL: run incomplete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/up_tb.sv
`timescale 1ns/1ps

module up_tb import up_pkg::*; ();

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int RUNS         = 10;
   localparam int RUN_CYCLES   = 200;   // Reset, load, execute and read back
   localparam int HALT_LIMIT   = 100;

   logic         clk;
   logic         nRst;
   logic         start;
   logic         host_we;
   byte_t        host_addr;
   byte_t        host_wdata;
   byte_t        host_rdata;
   logic         busy;
   logic         halted;
   int           test_id;
   logic [127:0] code_img;
   logic [127:0] const_img;
   logic [15:0]  const_used;
   logic         model_go;
   logic         obs_valid;
   int           check_errors;
   int           run_errors;
   logic [15:0]  lfsr;
   nib_t         prog_q [$];

   up_top dut0 (
      .clk        (clk),
      .nRst       (nRst),
      .start      (start),
      .host_we    (host_we),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_rdata (host_rdata),
      .busy       (busy),
      .halted     (halted)
   );

   up_tb_checks checks0 (
      .clk       (clk),
      .nRst      (nRst),
      .start     (start),
      .busy      (busy),
      .halted    (halted),
      .test_id   (test_id),
      .code_img  (code_img),
      .const_img (const_img),
      .model_go  (model_go),
      .obs_valid (obs_valid),
      .obs_addr  (host_addr),
      .obs_data  (host_rdata),
      .errors    (check_errors)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic lfsr_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
         lfsr = lfsr ^ 16'hB400;   // Galois taps 16,14,13,11
      return b;
   endfunction

   function automatic byte_t rand_bits(int count);
      byte_t v;
      v = 8'h00;
      repeat (count) v = {v[6:0], lfsr_bit()};
      return v;
   endfunction

   task automatic new_program(int id);
      test_id = id;
      prog_q.delete();
      const_img = '0;
      const_used = '0;
   endtask

   task automatic emit(opcode_e op);
      prog_q.push_back(nib_t'(op));
   endtask

   task automatic emit_seq(opcode_e ops [$]);
      foreach (ops[i])
         emit(ops[i]);
   endtask

   // Constant slot follows the pc after the LDI fetch
   task automatic emit_ldi(byte_t value);
      int slot;
      slot = (prog_q.size() + 1) >> 1;
      if (const_used[slot]) begin
         $display("Constant slot %0d used twice in test %0d", slot, test_id);
         run_errors++;
      end
      const_used[slot] = 1'b1;
      const_img[slot*8 +: 8] = value;
      emit(LDI);
   endtask

   task automatic host_write(byte_t addr, byte_t data);
      @(posedge clk);
      #1;
      host_we = 1'b1;
      host_addr = addr;
      host_wdata = data;
   endtask

   task automatic load_program();
      int i;
      code_img = '1;   // Pad with HALT
      for (i = 0; i < prog_q.size(); i++)
         code_img[(i >> 1) * 8 + ((i % 2 == 1) ? 0 : 4) +: 4] = prog_q[i];
      for (i = 0; i < 16; i++)
         host_write(byte_t'(i), code_img[i*8 +: 8]);
      for (i = 0; i < 16; i++)
         host_write(CONST_BASE | byte_t'(i), const_img[i*8 +: 8]);
      for (i = 8'hF8; i <= 8'hFF; i++)
         host_write(byte_t'(i), byte_t'(i));   // Stack bytes hold their own address
      @(posedge clk);
      #1;
      host_we = 1'b0;
      model_go = 1'b1;
      @(posedge clk);
      #1;
      model_go = 1'b0;
   endtask

   task automatic run_program();
      int cycles;
      @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      cycles = 0;
      while (!halted && cycles < HALT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("Core did not halt within %0d cycles in test %0d", HALT_LIMIT, test_id);
         run_errors++;
      end
   endtask

   task automatic observe(byte_t addr);
      @(posedge clk);
      #1;
      host_addr = addr;
      obs_valid = 1'b1;
   endtask

   task automatic read_back(byte_t extra);
      int a;
      for (a = 8'hF8; a <= 8'hFF; a++)
         observe(byte_t'(a));
      observe(extra);
      @(posedge clk);
      #1;
      obs_valid = 1'b0;
   endtask

   task automatic apply_reset();
      nRst = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      nRst = 1'b1;
   endtask

   task automatic execute_test(byte_t extra);
      apply_reset();
      load_program();
      run_program();
      read_back(extra);
   endtask

   initial begin
      #(RUNS * RUN_CYCLES * CLK_PERIOD);
      $display("Watchdog expired, %0d checks and %0d run errors so far",
               check_errors, run_errors);
      $display("Verification failed");
      $finish;
   end

   initial begin
      byte_t   k0;
      byte_t   k1;
      int      n;
      opcode_e arith_ops [5];
      nRst = 1'b0;
      start = 1'b0;
      host_we = 1'b0;
      host_addr = 8'h00;
      host_wdata = 8'h00;
      model_go = 1'b0;
      obs_valid = 1'b0;
      test_id = 0;
      run_errors = 0;
      lfsr = 16'd71;
      code_img = '1;
      const_img = '0;
      const_used = '0;

      new_program(1);
      emit(HALT);
      execute_test(8'hFF);

      arith_ops = '{ADD, SUB, MUL, DIV, NAND};   // r2 stays 3, so DIV is safe
      for (n = 0; n < 5; n++) begin
         new_program(2 + n);
         emit_ldi(rand_bits(8));
         emit_seq('{arith_ops[n], SWAP12, PUSH, HALT});
         execute_test(8'hFF);
      end

      new_program(7);
      emit_seq('{SWAP01, SWAP12, SWAP23, PUSH, SWAP12, PUSH,
                 SWAP01, SWAP12, PUSH, SWAP23, PUSH, HALT});
      execute_test(8'hFF);

      k0 = rand_bits(8);
      k1 = 8'h40 | rand_bits(6);   // Data address clear of code and constants
      new_program(8);
      emit_ldi(k1);
      emit_seq('{SWAP12, SWAP23});
      emit_ldi(k0);
      emit_seq('{SWAP12, ST, LD, INC, SWAP01, SWAP12, PUSH, HALT});
      execute_test(k1);

      new_program(9);
      emit_ldi(rand_bits(8));
      emit_seq('{SWAP12, PUSH});
      emit_ldi(rand_bits(8));
      emit_seq('{SWAP12, PUSH, POP, SWAP12, POP, SWAP12, PUSH, SWAP12, PUSH, HALT});
      execute_test(8'hFF);

      new_program(10);
      emit_ldi(8'd5);   // Nibble after the guard HALT
      emit_seq('{SWAP12, XPC, INC, HALT, SWAP01, SWAP12, PUSH, HALT});
      execute_test(8'hFF);

      $display("Errors: %0d total, %0d from checks, %0d from runs",
               check_errors + run_errors, check_errors, run_errors);
      if (check_errors + run_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// File: sim/up_tb_checks.sv
`timescale 1ns/1ps

module up_tb_checks import up_pkg::*; (
   input  logic         clk,
   input  logic         nRst,
   input  logic         start,
   input  logic         busy,
   input  logic         halted,
   input  int           test_id,
   input  logic [127:0] code_img,    // Code bytes 00..0f
   input  logic [127:0] const_img,   // Constant bytes 80..8f
   input  logic         model_go,
   input  logic         obs_valid,
   input  byte_t        obs_addr,
   input  byte_t        obs_data,
   output int           errors
);

   byte_t model_mem [MEM_DEPTH];
   int    data_errors = 0;
   int    reset_errors = 0;
   int    latency_errors = 0;
   int    busy_errors = 0;

   assign errors = data_errors + reset_errors + latency_errors + busy_errors;

   function automatic string test_name(int id);
      case (id)
         1:       return "halt_only";
         2:       return "arith_add";
         3:       return "arith_sub";
         4:       return "arith_mul";
         5:       return "arith_div";
         6:       return "arith_nand";
         7:       return "swaps";
         8:       return "load_store";
         9:       return "stack_order";
         10:      return "xpc_jump";
         default: return "unknown";
      endcase
   endfunction

   // Instruction level model of the ISA, run on the loaded image
   task automatic run_model();
      byte_t   r [4];
      byte_t   pc;
      byte_t   sp;
      byte_t   t;
      opcode_e op;
      int      i;
      int      steps;
      for (i = 0; i < MEM_DEPTH; i++)
         model_mem[i] = byte_t'(i);   // Stack area is preset to its own address
      for (i = 0; i < 16; i++) begin
         model_mem[i] = code_img[i*8 +: 8];
         model_mem[CONST_BASE | byte_t'(i)] = const_img[i*8 +: 8];
      end
      r[0] = 8'd1;
      r[1] = 8'd2;
      r[2] = 8'd3;
      r[3] = 8'd4;
      pc = 8'h00;
      sp = 8'hFF;
      op = ADD;
      steps = 0;
      while (op != HALT && steps < 64) begin
         t = model_mem[{1'b0, pc[7:1]}];
         op = opcode_e'(pc[0] ? t[3:0] : t[7:4]);   // High nibble first
         pc = pc + 8'd1;
         case (op)
            ADD:    r[1] = r[1] + r[2];
            SUB:    r[1] = r[1] - r[2];
            MUL:    r[1] = r[1] * r[2];
            DIV:    r[1] = r[1] / r[2];
            SWAP01: {r[0], r[1]} = {r[1], r[0]};
            SWAP12: {r[1], r[2]} = {r[2], r[1]};
            SWAP23: {r[2], r[3]} = {r[3], r[2]};
            XPC:    {pc, r[2]} = {r[2], pc};
            LD:     r[0] = model_mem[r[3]];
            ST:     model_mem[r[3]] = r[2];
            INC:    r[0] = r[0] + 8'd1;
            NAND:   r[1] = ~(r[1] & r[2]);
            LDI:    r[1] = model_mem[CONST_BASE | {1'b0, pc[7:1]}];   // Uses next pc
            PUSH: begin
               sp = sp - 8'd1;
               model_mem[sp] = r[2];
            end
            POP: begin
               r[2] = model_mem[sp];
               sp = sp + 8'd1;
            end
            default: ;
         endcase
         steps++;
      end
   endtask

   always @(posedge clk) begin
      if (model_go)
         run_model();
      if (obs_valid) begin
         assert (obs_data == model_mem[obs_addr])
            else begin
               $display("CHECK FAILED %s mem[%02h] expected %02h actual %02h",
                        test_name(test_id), obs_addr, model_mem[obs_addr], obs_data);
               data_errors++;
            end
         assert (halted)
            else begin
               $display("CHECK FAILED %s halted expected 1 actual %0b",
                        test_name(test_id), halted);
               data_errors++;
            end
      end
   end

   a_reset_quiet: assert property (@(posedge clk) $rose(nRst) |-> (!busy && !halted))
      else begin
         $display("CHECK FAILED %s reset expected busy=0 halted=0 actual busy=%0b halted=%0b",
                  test_name(test_id), busy, halted);
         reset_errors++;
      end

   // Fetch 2 cycles plus HALT execute 1 cycle
   a_halt_latency: assert property (@(posedge clk) disable iff (!nRst)
      (start && test_id == 1) |-> ##3 halted)
      else begin
         $display("CHECK FAILED %s halted 3 cycles after start expected 1 actual 0",
                  test_name(test_id));
         latency_errors++;
      end

   // Core runs from the cycle after start
   a_busy_after_start: assert property (@(posedge clk) disable iff (!nRst)
      (start && !busy) |=> busy)
      else begin
         $display("CHECK FAILED %s busy after start expected 1 actual 0",
                  test_name(test_id));
         busy_errors++;
      end

   a_busy_halted_excl: assert property (@(posedge clk) disable iff (!nRst)
      !(busy && halted))
      else begin
         $display("CHECK FAILED %s busy while halted expected 0 actual 1",
                  test_name(test_id));
         busy_errors++;
      end

endmodule

// File: hdl/up_top.sv
`timescale 1ns/1ps

module up_top import up_pkg::*; (
   input  logic  clk,
   input  logic  nRst,
   input  logic  start,
   input  logic  host_we,
   input  byte_t host_addr,
   input  byte_t host_wdata,
   output byte_t host_rdata,
   output logic  busy,
   output logic  halted
);

   ctrl_t ctrl;
   byte_t bus;       // Shared data_out bus
   byte_t rd_data;
   nib_t  ir;

   up_control u_control (
      .clk    (clk),
      .nRst   (nRst),
      .start  (start),
      .ir     (ir),
      .ctrl   (ctrl),
      .busy   (busy),
      .halted (halted)
   );

   up_datapath u_datapath (
      .clk      (clk),
      .nRst     (nRst),
      .data_in  (rd_data),
      .ctrl     (ctrl),
      .data_out (bus),
      .ir       (ir)
   );

   up_memory u_memory (
      .clk        (clk),
      .nRst       (nRst),
      .addr_wdata (bus),
      .mar_we     (ctrl.mar_we),
      .mem_we     (ctrl.mem_we),
      .rd_data    (rd_data),
      .busy       (busy),
      .host_we    (host_we),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_rdata (host_rdata)
   );

endmodule

// File: hdl/up_memory.sv
`timescale 1ns/1ps

module up_memory import up_pkg::*; (
   input  logic  clk,
   input  logic  nRst,
   input  byte_t addr_wdata,
   input  logic  mar_we,
   input  logic  mem_we,
   output byte_t rd_data,
   input  logic  busy,
   input  logic  host_we,
   input  byte_t host_addr,
   input  byte_t host_wdata,
   output byte_t host_rdata
);

   byte_t mem [MEM_DEPTH];
   byte_t mar;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst)
         mar <= 8'h00;
      else if (mar_we)
         mar <= addr_wdata;   // Bus carries the address
   end

   // Host owns the array only while the core is stopped
   always_ff @(posedge clk) begin
      if (host_we)
         mem[host_addr] <= host_wdata;
      else if (mem_we)
         mem[mar] <= addr_wdata;
   end

   assign rd_data    = mem[mar];
   assign host_rdata = mem[host_addr];

   a_host_idle: assert property (@(posedge clk) disable iff (!nRst)
      host_we |-> !busy)
      else $error("host write at %0h while core busy", host_addr);

endmodule

// File: up_core/up_control.sv
`timescale 1ns/1ps

module up_control import up_pkg::*; (
   input  logic  clk,
   input  logic  nRst,
   input  logic  start,
   input  nib_t  ir,
   output ctrl_t ctrl,
   output logic  busy,
   output logic  halted
);

   typedef enum logic [2:0] {
      IDLE,
      FETCH_ADDR,
      FETCH_IR,
      EXEC1,
      EXEC2,
      EXEC3,
      HALTED
   } state_e;

   state_e     state;
   state_e     state_nxt;
   opcode_e    op;
   logic [1:0] step;       // Execute step, 0 based
   logic [1:0] op_len;     // Index of last execute step
   logic       last;
   logic       halt_exec;

   // Step that writes a register
   function automatic ctrl_t wr_reg(alu_sel_e s, rb_sel_e r);
      ctrl_t c;
      c        = '0;
      c.sel    = s;
      c.rb_we  = 1'b1;
      c.rb_sel = r;
      return c;
   endfunction

   // Step that drives pointer and memory strobes
   function automatic ctrl_t wr_strobe(alu_sel_e s, logic pc_we, logic sp_we,
                                       logic mar_we, logic mem_we);
      ctrl_t c;
      c        = '0;
      c.sel    = s;
      c.pc_we  = pc_we;
      c.sp_we  = sp_we;
      c.mar_we = mar_we;
      c.mem_we = mem_we;
      return c;
   endfunction

   assign op        = opcode_e'(ir);
   assign step      = (state == EXEC3) ? 2'd2 : (state == EXEC2) ? 2'd1 : 2'd0;
   assign halt_exec = (state == EXEC1) && (op == HALT);
   assign halted    = (state == HALTED) || halt_exec;
   assign busy      = !(state inside {IDLE, HALTED}) && !halt_exec;

   always_comb begin
      case (op)
         LD, ST, LDI, PUSH:        op_len = 2'd1;
         SWAP01, SWAP12, SWAP23,
         XPC, POP:                 op_len = 2'd2;
         default:                  op_len = 2'd0;   // ALU ops, INC, NAND, HALT
      endcase
   end

   assign last = (step == op_len);

   // Microcode table
   always_comb begin
      ctrl = '0;
      case (state)
         FETCH_ADDR: ctrl = wr_strobe(PC_CODE, 1'b0, 1'b0, 1'b1, 1'b0);
         FETCH_IR: begin
            ctrl       = wr_strobe(PC_INC, 1'b1, 1'b0, 1'b0, 1'b0);
            ctrl.ir_we = 1'b1;
         end
         EXEC1, EXEC2, EXEC3: begin
            case (op)
               ADD:    ctrl = wr_reg(ADD_12, SEL_O1);
               SUB:    ctrl = wr_reg(SUB_12, SEL_O1);
               MUL:    ctrl = wr_reg(MUL_12, SEL_O1);
               DIV:    ctrl = wr_reg(DIV_12, SEL_O1);
               SWAP01: ctrl = wr_reg(XOR_01, step[0] ? SEL_O1 : SEL_O0);   // x, y, x
               SWAP12: ctrl = wr_reg(XOR_12, step[0] ? SEL_O2 : SEL_O1);
               SWAP23: ctrl = wr_reg(XOR_23, step[0] ? SEL_O3 : SEL_O2);
               XPC:    ctrl = step[0] ? wr_reg(XOR_PC2, SEL_O2)
                                      : wr_strobe(XOR_PC2, 1'b1, 1'b0, 1'b0, 1'b0);
               LD:     ctrl = (step == 2'd0) ? wr_strobe(PASS_R3A, 1'b0, 1'b0, 1'b1, 1'b0)
                                             : wr_reg(PASS_DIN, SEL_I0);
               ST:     ctrl = (step == 2'd0) ? wr_strobe(PASS_R3B, 1'b0, 1'b0, 1'b1, 1'b0)
                                             : wr_strobe(PASS_R2, 1'b0, 1'b0, 1'b0, 1'b1);
               INC:    ctrl = wr_reg(INC_R0, SEL_O0);
               NAND:   ctrl = wr_reg(NAND_12, SEL_O1);
               LDI:    ctrl = (step == 2'd0) ? wr_strobe(PC_CONST, 1'b0, 1'b0, 1'b1, 1'b0)
                                             : wr_reg(PASS_DIN, SEL_I1);
               PUSH:   ctrl = (step == 2'd0) ? wr_strobe(SP_DEC, 1'b0, 1'b1, 1'b1, 1'b0)
                                             : wr_strobe(PASS_R2, 1'b0, 1'b0, 1'b0, 1'b1);
               POP: begin
                  case (step)
                     2'd0:    ctrl = wr_strobe(SP_INC, 1'b0, 1'b1, 1'b0, 1'b0);
                     2'd1:    ctrl = wr_strobe(SP_DEC, 1'b0, 1'b0, 1'b1, 1'b0);
                     default: ctrl = wr_reg(PASS_DIN, SEL_I2);
                  endcase
               end
               default: ctrl = '0;   // HALT
            endcase
         end
         default: ctrl = '0;
      endcase
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE, HALTED: if (start) state_nxt = FETCH_ADDR;
         FETCH_ADDR:   state_nxt = FETCH_IR;
         FETCH_IR:     state_nxt = EXEC1;
         default: begin
            if (last)
               state_nxt = (op == HALT) ? HALTED : FETCH_ADDR;
            else
               state_nxt = (state == EXEC1) ? EXEC2 : EXEC3;
         end
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst)
         state <= IDLE;
      else
         state <= state_nxt;
   end

   // Host may own the memory whenever busy is low
   a_quiet_when_stopped: assert property (@(posedge clk) disable iff (!nRst)
      !busy |-> (ctrl == '0))
      else $error("ctrl active while not busy, state %s", state.name());

   // Memory would write to a stale address
   a_no_mar_mem_overlap: assert property (@(posedge clk) disable iff (!nRst)
      !(ctrl.mem_we && ctrl.mar_we))
      else $error("mem_we with mar_we, op %s step %0d", op.name(), step);

endmodule

// File: up_core/up_datapath.sv
`timescale 1ns/1ps

module up_datapath import up_pkg::*; (
   input  logic  clk,
   input  logic  nRst,
   input  byte_t data_in,
   input  ctrl_t ctrl,
   output byte_t data_out,
   output nib_t  ir
);

   byte_t pc;   // Counts nibbles
   byte_t sp;
   byte_t r0;
   byte_t r1;
   byte_t r2;
   byte_t r3;

   always_comb begin
      case (ctrl.sel)
         ADD_12:   data_out = r1 + r2;
         SUB_12:   data_out = r1 - r2;
         MUL_12:   data_out = r1 * r2;   // Low byte only
         DIV_12:   data_out = r1 / r2;

         XOR_01:   data_out = r0 ^ r1;
         XOR_12:   data_out = r1 ^ r2;
         XOR_23:   data_out = r2 ^ r3;
         XOR_PC2:  data_out = pc ^ r2;

         PASS_R3A: data_out = r3;
         PASS_R3B: data_out = r3;
         INC_R0:   data_out = r0 + 8'h01;
         NAND_12:  data_out = ~(r1 & r2);

         ZERO:     data_out = 8'h00;
         SP_INC:   data_out = sp + 8'h01;
         SP_DEC:   data_out = sp - 8'h01;
         PASS_R2:  data_out = r2;
         PASS_PC:  data_out = pc;
         PC_CODE:  data_out = (pc >> 1) & ~CONST_BASE;   // Code byte address
         PC_CONST: data_out = (pc >> 1) | CONST_BASE;
         PC_INC:   data_out = pc + 8'h01;
         default:  data_out = data_in;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= 8'h00;
         sp <= SP_RESET;
         ir <= 4'h0;
         r0 <= REG_RESET[0];
         r1 <= REG_RESET[1];
         r2 <= REG_RESET[2];
         r3 <= REG_RESET[3];
      end else begin
         // Odd nibble sits in the low half
         if (ctrl.ir_we) begin
            if (pc[0])
               ir <= data_in[3:0];
            else
               ir <= data_in[7:4];
         end
         if (ctrl.sp_we)
            sp <= data_out;
         if (ctrl.pc_we)
            pc <= data_out;
         if (ctrl.rb_we) begin
            case (ctrl.rb_sel)
               SEL_I0: r0 <= data_in;
               SEL_I1: r1 <= data_in;
               SEL_I2: r2 <= data_in;
               SEL_I3: r3 <= data_in;
               SEL_O0: r0 <= data_out;
               SEL_O1: r1 <= data_out;
               SEL_O2: r2 <= data_out;
               SEL_O3: r3 <= data_out;
            endcase
         end
      end
   end

   // Single bus can only feed one pointer register
   a_pc_sp_excl: assert property (@(posedge clk) disable iff (!nRst)
      !(ctrl.pc_we && ctrl.sp_we))
      else $error("pc_we and sp_we both high, sel %0h", ctrl.sel);

endmodule

// File: common/up_pkg.sv
package up_pkg;

   typedef logic [7:0] byte_t;   // Data and address word
   typedef logic [3:0] nib_t;    // One instruction

   localparam int    MEM_DEPTH  = 256;
   localparam byte_t SP_RESET   = 8'hFF;
   localparam byte_t CONST_BASE = 8'h80;   // LDI constant region

   // Reset values, index 0 is r0
   localparam byte_t [3:0] REG_RESET = {8'h04, 8'h03, 8'h02, 8'h01};

   typedef enum logic [3:0] {
      ADD, SUB, MUL, DIV,
      SWAP01, SWAP12, SWAP23, XPC,
      LD, ST, INC, NAND,
      LDI, PUSH, POP, HALT
   } opcode_e;

   typedef enum logic [4:0] {
      ADD_12   = 5'b00000,
      SUB_12   = 5'b00001,
      MUL_12   = 5'b00010,
      DIV_12   = 5'b00011,
      XOR_01   = 5'b00100,
      XOR_12   = 5'b00101,
      XOR_23   = 5'b00110,
      XOR_PC2  = 5'b00111,
      PASS_R3A = 5'b01000,
      PASS_R3B = 5'b01001,
      INC_R0   = 5'b01010,
      NAND_12  = 5'b01011,
      PASS_DIN = 5'b01111,   // Any unlisted code passes data_in
      ZERO     = 5'b10000,
      PASS_R2  = 5'b11000,
      SP_INC   = 5'b11010,
      SP_DEC   = 5'b11011,
      PASS_PC  = 5'b11100,
      PC_CODE  = 5'b11101,
      PC_CONST = 5'b11110,
      PC_INC   = 5'b11111
   } alu_sel_e;

   typedef enum logic [2:0] {
      SEL_I0, SEL_I1, SEL_I2, SEL_I3,   // From data_in
      SEL_O0, SEL_O1, SEL_O2, SEL_O3    // From data_out
   } rb_sel_e;

   typedef struct packed {
      alu_sel_e sel;
      logic     ir_we;
      logic     pc_we;
      logic     sp_we;
      logic     rb_we;
      rb_sel_e  rb_sel;
      logic     mar_we;   // Memory side
      logic     mem_we;
   } ctrl_t;

endpackage
